/* filelist.f */
hw/decodePkg.sv
hw/decodeIf.sv
hw/decodeImm.sv
hw/decodeRa.sv
hw/decodeRt.sv
hw/decodeStage.sv
hw/regReadStage.sv
hw/decodeTop.sv
tests/decodeTb.sv

/* hw/decodeIf.sv */
// Decoded instruction channel
`timescale 1ns/100ps

interface decodeIf import decodePkg::*; #(
	parameter int dataWidth = 32
) ();

	// Handshake
	logic valid;
	logic ready;

	// Register numbers after banking
	aregNo_t raNo;
	aregNo_t rbNo;
	aregNo_t rtNo;
	logic aZero;

	// Constants that override the register operands
	logic hasImma;
	logic [dataWidth-1:0] immA;
	logic useImmB;
	logic [dataWidth-1:0] immB;

	modport producer
	(
		output valid, raNo, rbNo, rtNo, aZero, hasImma, immA, useImmB, immB,
		input ready
	);

	modport consumer
	(
		input valid, raNo, rbNo, rtNo, aZero, hasImma, immA, useImmB, immB,
		output ready
	);

endinterface

/* hw/decodeImm.sv */
// Immediate constant decoder
`timescale 1ns/100ps

module decodeImm import decodePkg::*; #(
	parameter int dataWidth = 32
) (
	input logic clk,
	input logic reset,
	input logic accept,
	input instruction_t instr,
	output logic hasImma,
	output logic [dataWidth-1:0] immA,
	output logic [dataWidth-1:0] immB,
	output logic useImmB,
	output logic isPrefix
);

	// Sign-extended immediate field of the current word
	logic [dataWidth-1:0] immExt;

	// Constant from the last prefix and whether it is still waiting for use
	logic [dataWidth-1:0] prefixValue;
	logic pending;

	assign immExt = {{(dataWidth - 13){instr.i.imm[12]}}, instr.i.imm};
	assign isPrefix = (instr.i.opcode == IMMA);

	// Operand B constant comes straight from the word
	assign useImmB = isImmForm(instr.i.opcode);
	assign immB = immExt;

	// The held prefix applies to whichever instruction is accepted next
	assign hasImma = pending;
	assign immA = prefixValue;

	always_ff @(posedge clk)
	begin
		if (reset)
			pending <= 1'b0;
		else if (accept)
			pending <= isPrefix;
	end

	// Constant captured from the most recent prefix word
	always_ff @(posedge clk)
	begin
		if (accept && isPrefix)
			prefixValue <= immExt;
	end

endmodule

/* hw/decodePkg.sv */
// Decode front end definitions
package decodePkg;

	// ==============================
	// Register numbers and modes
	// ==============================

	// Architectural register number covering general, banked and special registers
	typedef logic [5:0] aregNo_t;

	// Operating mode, 3 selects machine mode
	typedef logic [1:0] operatingMode_t;

	localparam operatingMode_t machineMode = 2'd3;

	// Special register numbers
	localparam aregNo_t zeroReg = 6'd0;
	localparam aregNo_t stackReg = 6'd31;
	localparam aregNo_t spIplBase = 6'd32;
	localparam aregNo_t spModeBase = 6'd40;
	localparam aregNo_t loopReg = 6'd55;

	// ==============================
	// Instruction formats
	// ==============================

	typedef enum logic [6:0]
	{
		ADD = 7'h02,
		SUB = 7'h03,
		ADDI = 7'h04,
		ANDI = 7'h08,
		ADDSI = 7'h0C,
		LDI = 7'h0D,
		DBRA = 7'h28,
		RTD = 7'h29,
		IMMA = 7'h30
	} opcode_t;

	// Register form, members listed from the top bit down
	typedef struct packed
	{
		logic [6:0] spare;
		aregNo_t rb;
		aregNo_t ra;
		aregNo_t rt;
		opcode_t opcode;
	} regForm_t;

	// Immediate form, the 13-bit constant sits where rb and spare are
	typedef struct packed
	{
		logic [12:0] imm;
		aregNo_t ra;
		aregNo_t rt;
		opcode_t opcode;
	} immForm_t;

	// The same word read either way
	typedef union packed
	{
		regForm_t r;
		immForm_t i;
	} instruction_t;

	// Register 31 selects a banked stack pointer
	function automatic aregNo_t bankSp(aregNo_t regNo, operatingMode_t om, logic [2:0] ipl);
		aregNo_t result;
		result = regNo;
		if (regNo == stackReg)
		begin
			// Machine mode banks by interrupt level, the others by mode
			if (om == machineMode)
				result = spIplBase + aregNo_t'(ipl);
			else
				result = spModeBase + aregNo_t'(om);
		end
		return result;
	endfunction

	// Opcodes whose operand B comes from the immediate field
	function automatic logic isImmForm(opcode_t op);
		return op inside {ADDI, ANDI, ADDSI, LDI};
	endfunction

endpackage

/* hw/decodeRa.sv */
// Operand A register decoder
`timescale 1ns/100ps

module decodeRa import decodePkg::*; (
	input operatingMode_t om,
	input logic [2:0] ipl,
	input instruction_t instr,
	input logic hasImma,
	output aregNo_t ra,
	output logic raZero
);

	// Register number before stack pointer banking
	aregNo_t raRaw;

	always_comb
	begin
		if (hasImma)
			raRaw = zeroReg;
		else
		begin
			case (instr.r.opcode)
				// Return reads one of the upper four return-target slots
				RTD:
					if (instr.r.ra[2:0] < 3'd4)
						raRaw = zeroReg;
					else
						raRaw = {3'b101, instr.r.ra[2:0]};
				DBRA:
					raRaw = loopReg;
				// Add-to-self reads its own target
				ADDSI:
					raRaw = instr.i.rt;
				LDI:
					raRaw = zeroReg;
				default:
					raRaw = instr.r.ra;
			endcase
		end
	end

	assign ra = bankSp(raRaw, om, ipl);
	assign raZero = (ra == zeroReg);

endmodule

/* hw/decodeRt.sv */
// Target register decoder
`timescale 1ns/100ps

module decodeRt import decodePkg::*; (
	input operatingMode_t om,
	input logic [2:0] ipl,
	input instruction_t instr,
	output aregNo_t rt
);

	// Target before stack pointer banking
	aregNo_t rtRaw;

	always_comb
	begin
		// Decrement and branch always writes the loop counter
		if (instr.r.opcode == DBRA)
			rtRaw = loopReg;
		else
			rtRaw = instr.r.rt;
	end

	assign rt = bankSp(rtRaw, om, ipl);

endmodule

/* hw/decodeStage.sv */
// Instruction decode pipeline stage
`timescale 1ns/100ps

module decodeStage import decodePkg::*; #(
	parameter int dataWidth = 32
) (
	input logic clk,
	input logic reset,
	input operatingMode_t om,
	input logic [2:0] ipl,
	input instruction_t instr,
	input logic instrValid,
	output logic instrReady,
	decodeIf.producer dec
);

	logic accept;

	// Decoder results for the incoming word
	logic hasImma;
	logic [dataWidth-1:0] immA;
	logic [dataWidth-1:0] immB;
	logic useImmB;
	logic isPrefix;
	aregNo_t raNo;
	logic raZero;
	aregNo_t rtNo;
	aregNo_t rbNo;

	// ==============================
	// Decoders
	// ==============================

	decodeImm #(.dataWidth(dataWidth)) immDec
	(
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.instr(instr),
		.hasImma(hasImma),
		.immA(immA),
		.immB(immB),
		.useImmB(useImmB),
		.isPrefix(isPrefix)
	);

	decodeRa raDec
	(
		.om(om),
		.ipl(ipl),
		.instr(instr),
		.hasImma(hasImma),
		.ra(raNo),
		.raZero(raZero)
	);

	decodeRt rtDec
	(
		.om(om),
		.ipl(ipl),
		.instr(instr),
		.rt(rtNo)
	);

	// Immediate forms have no rb field, so read register 0 instead
	assign rbNo = useImmB ? zeroReg : bankSp(instr.r.rb, om, ipl);

	// ==============================
	// Output register
	// ==============================

	// Room when empty or when the word held now leaves this cycle
	assign instrReady = !dec.valid || dec.ready;
	assign accept = instrValid && instrReady;

	always_ff @(posedge clk)
	begin
		if (reset)
			dec.valid <= 1'b0;
		else if (accept && !isPrefix)
			dec.valid <= 1'b1;
		else if (dec.ready)
			dec.valid <= 1'b0;
	end

	// A prefix only loads the immediate decoder and leaves this register alone
	always_ff @(posedge clk)
	begin
		if (accept && !isPrefix)
		begin
			dec.raNo <= raNo;
			dec.rbNo <= rbNo;
			dec.rtNo <= rtNo;
			dec.aZero <= raZero;
			dec.hasImma <= hasImma;
			dec.immA <= immA;
			dec.useImmB <= useImmB;
			dec.immB <= immB;
		end
	end

	// An offered instruction word stays put until this stage takes it
	holdInstr: assert property (@(posedge clk) disable iff (reset)
		instrValid && !instrReady |=> instrValid && $stable(instr))
		else $error("instruction changed while stalled");

endmodule

/* hw/decodeTop.sv */
// Decode and register read top level
`timescale 1ns/100ps

module decodeTop import decodePkg::*; #(
	parameter int dataWidth = 32
) (
	input logic clk,
	input logic reset,
	input operatingMode_t om,
	input logic [2:0] ipl,
	input instruction_t instr,
	input logic instrValid,
	output logic instrReady,
	input logic regWrite,
	input aregNo_t regWriteAddr,
	input logic [dataWidth-1:0] regWriteData,
	output logic outValid,
	input logic outReady,
	output logic [dataWidth-1:0] operandA,
	output logic [dataWidth-1:0] operandB,
	output aregNo_t rt
);

	// Decoded word between the two stages
	decodeIf #(.dataWidth(dataWidth)) decBus ();

	decodeStage #(.dataWidth(dataWidth)) decStage
	(
		.clk(clk),
		.reset(reset),
		.om(om),
		.ipl(ipl),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.dec(decBus.producer)
	);

	regReadStage #(.dataWidth(dataWidth)) readStage
	(
		.clk(clk),
		.reset(reset),
		.dec(decBus.consumer),
		.regWrite(regWrite),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData),
		.outValid(outValid),
		.outReady(outReady),
		.operandA(operandA),
		.operandB(operandB),
		.rt(rt)
	);

endmodule

/* hw/regReadStage.sv */
// Register file and operand read stage
`timescale 1ns/100ps

module regReadStage import decodePkg::*; #(
	parameter int dataWidth = 32
) (
	input logic clk,
	input logic reset,
	decodeIf.consumer dec,
	input logic regWrite,
	input aregNo_t regWriteAddr,
	input logic [dataWidth-1:0] regWriteData,
	output logic outValid,
	input logic outReady,
	output logic [dataWidth-1:0] operandA,
	output logic [dataWidth-1:0] operandB,
	output aregNo_t rt
);

	// ==============================
	// Register file
	// ==============================

	logic [dataWidth-1:0] regFile [0:63];

	// Register values for the word waiting on the interface
	logic [dataWidth-1:0] aValue;
	logic [dataWidth-1:0] bValue;

	logic accept;

	// Writes land at the edge, so a read in the same cycle sees the old value
	always_ff @(posedge clk)
	begin
		if (regWrite)
			regFile[regWriteAddr] <= regWriteData;
	end

	// Register 0 reads zero whatever was written to it
	assign aValue = dec.aZero ? '0 : regFile[dec.raNo];
	assign bValue = (dec.rbNo == zeroReg) ? '0 : regFile[dec.rbNo];

	// ==============================
	// Operand register
	// ==============================

	assign dec.ready = !outValid || outReady;
	assign accept = dec.valid && dec.ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else if (accept)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// Constants from the decoder override the register reads
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			operandA <= dec.hasImma ? dec.immA : aValue;
			operandB <= dec.useImmB ? dec.immB : bValue;
			rt <= dec.rtNo;
		end
	end

	// The decoded word on the interface holds steady until this stage takes it
	heldDecode: assert property (@(posedge clk) disable iff (reset)
		dec.valid && !dec.ready |=> dec.valid && $stable({dec.raNo, dec.rbNo, dec.rtNo,
			dec.aZero, dec.hasImma, dec.immA, dec.useImmB, dec.immB}))
		else $error("decoded word changed while stalled");

endmodule

/* tests/decodeTb.sv */
// Decode front end testbench
`timescale 1ns/100ps

module decodeTb import decodePkg::*; ();

	localparam int dataWidth = 32;
	localparam string dataPath = "tests/decodeTestdata.txt";

	logic clk;
	logic reset;
	operatingMode_t om;
	logic [2:0] ipl;
	instruction_t instr;
	logic instrValid;
	logic instrReady;
	logic regWrite;
	aregNo_t regWriteAddr;
	logic [dataWidth-1:0] regWriteData;
	logic outValid;
	logic outReady;
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	aregNo_t rt;

	// Expected results in issue order, one entry per non-prefix instruction
	logic [dataWidth-1:0] expAQ[$];
	logic [dataWidth-1:0] expBQ[$];
	aregNo_t expRtQ[$];

	// Output as seen at the last falling edge while it was stalled
	logic holding = 1'b0;
	logic [dataWidth-1:0] heldA;
	logic [dataWidth-1:0] heldB;
	aregNo_t heldRt;

	int valueErrors = 0;
	int otherErrors = 0;
	int cycles = 0;
	int cycleLimit = 100000;
	logic [31:0] rngState;

	decodeTop #(.dataWidth(dataWidth)) uut
	(
		.clk(clk),
		.reset(reset),
		.om(om),
		.ipl(ipl),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.regWrite(regWrite),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData),
		.outValid(outValid),
		.outReady(outReady),
		.operandA(operandA),
		.operandB(operandB),
		.rt(rt)
	);

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int countLines();
		int fd;
		int count;
		string line;
		fd = $fopen(dataPath, "r");
		count = 0;
		if (fd != 0)
		begin
			while ($fgets(line, fd) != 0)
				count++;
			$fclose(fd);
		end
		return count;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
		valueErrors++;
	endtask

	// Holds the word until the decode stage takes it, returns just after the edge
	task automatic sendInstr(input operatingMode_t mode, input logic [2:0] level,
		input logic [31:0] word);
		om = mode;
		ipl = level;
		instr = word;
		instrValid = 1'b1;
		@(negedge clk);
		while (!instrReady)
			@(negedge clk);
		@(posedge clk);
		#1;
		instrValid = 1'b0;
	endtask

	task automatic writeReg(input aregNo_t addr, input logic [dataWidth-1:0] data);
		// Earlier instructions must have read their operands first
		while (expAQ.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
		regWrite = 1'b1;
		regWriteAddr = addr;
		regWriteData = data;
		@(posedge clk);
		#1;
		regWrite = 1'b0;
	endtask

	// Lines are W for a register write, I for an instruction, # for a comment
	task automatic runFile(input int fd);
		string kind;
		string field;
		string rest;
		int addr;
		int mode;
		int level;
		int expRt;
		int code;
		logic [31:0] value;
		logic [31:0] word;
		logic [31:0] expA;
		logic [31:0] expB;
		while ($fscanf(fd, "%s", kind) == 1)
		begin
			if (kind.getc(0) == "#")
				code = $fgets(rest, fd);
			else if (kind == "W")
			begin
				code = $fscanf(fd, "%d %h", addr, value);
				writeReg(aregNo_t'(addr), value);
			end
			else if (kind == "I")
			begin
				code = $fscanf(fd, "%d %d %h %s", mode, level, word, field);
				// A prefix has dashes and yields no output of its own
				if (field == "-")
					code = $fscanf(fd, "%s %s", field, rest);
				else
				begin
					code = $sscanf(field, "%h", expA);
					code = $fscanf(fd, "%h %d", expB, expRt);
					expAQ.push_back(expA);
					expBQ.push_back(expB);
					expRtQ.push_back(aregNo_t'(expRt));
				end
				sendInstr(operatingMode_t'(mode), 3'(level), word);
			end
			else
			begin
				$display("Data file holds a line of unknown kind %s", kind);
				otherErrors++;
				code = $fgets(rest, fd);
			end
		end
	endtask

	// ==============================
	// Clock, back-pressure, timeout
	// ==============================

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Output side is ready about three cycles in four
	initial
	begin
		rngState = 32'h4b69808a;
		outReady = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			rngState = xorshift(rngState);
			outReady = (rngState[1:0] != 2'b00);
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles with %0d results outstanding",
				cycles, expAQ.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	// ==============================
	// Output monitor
	// ==============================

	// Falling edge sees the values that the next rising edge transfers
	always @(negedge clk)
	begin
		logic [dataWidth-1:0] expA;
		logic [dataWidth-1:0] expB;
		aregNo_t expRt;
		if (!reset)
		begin
			if (holding)
			begin
				if (!outValid)
				begin
					$display("At %0t outValid fell before the result was taken", $time);
					otherErrors++;
				end
				else
				begin
					if (operandA !== heldA)
						reportMismatch("operandA while stalled", heldA, operandA);
					if (operandB !== heldB)
						reportMismatch("operandB while stalled", heldB, operandB);
					if (rt !== heldRt)
						reportMismatch("rt while stalled", 32'(heldRt), 32'(rt));
				end
			end
			holding = outValid && !outReady;
			heldA = operandA;
			heldB = operandB;
			heldRt = rt;
			if (outValid && outReady)
			begin
				if (expAQ.size() == 0)
				begin
					$display("At %0t a result came out with no instruction behind it", $time);
					otherErrors++;
				end
				else
				begin
					expA = expAQ.pop_front();
					expB = expBQ.pop_front();
					expRt = expRtQ.pop_front();
					if (operandA !== expA)
						reportMismatch("operandA", expA, operandA);
					if (operandB !== expB)
						reportMismatch("operandB", expB, operandB);
					if (rt !== expRt)
						reportMismatch("rt", 32'(expRt), 32'(rt));
				end
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		int fd;
		int drain;
		reset = 1'b1;
		om = '0;
		ipl = '0;
		instr = '0;
		instrValid = 1'b0;
		regWrite = 1'b0;
		regWriteAddr = '0;
		regWriteData = '0;
		// Generous per-line budget since writes wait for the pipeline to empty
		cycleLimit = 20 * countLines() + 200;
		repeat (5)
			@(posedge clk);
		#1;
		reset = 1'b0;
		fd = $fopen(dataPath, "r");
		if (fd == 0)
		begin
			$display("Could not open the data file %s", dataPath);
			otherErrors++;
		end
		else
		begin
			runFile(fd);
			$fclose(fd);
		end
		drain = 0;
		while (expAQ.size() != 0 && drain < 100)
		begin
			@(posedge clk);
			drain++;
		end
		if (expAQ.size() != 0)
		begin
			$display("%0d expected results never came out", expAQ.size());
			otherErrors++;
		end
		// A few idle cycles so a stray extra output would still be seen
		repeat (4)
			@(posedge clk);
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tests/decodeTestdata.txt */
# W register(decimal) value(hex)
# I om ipl instruction(hex) expectedA(hex) expectedB(hex) expectedRt(decimal) or dashes for IMMA
W 1 00000011
W 2 00000022
W 3 00000033
W 0 DEADBEEF
W 9 00000099
W 37 000000A5
W 42 000000B2
W 46 000000E6
W 55 00000055
I 0 0 00102202 00000011 00000022 4
I 0 0 00180283 00000000 00000033 5
I 0 0 00006082 00000033 00000000 1
I 3 5 000BEF82 000000A5 00000011 37
I 2 5 00F84F82 00000022 000000B2 42
I 0 0 000023A8 00000055 00000000 55
I 0 0 0028248C 00000099 00000005 9
I 0 0 0000C029 000000E6 00000000 0
I 0 0 000841A9 00000000 00000011 3
I 0 0 FFF8610D 00000000 FFFFFFFF 2
I 0 0 80002204 00000011 FFFFF000 4
I 0 0 07F84308 00000022 000000FF 6
I 0 0 91A00030 - - -
I 0 0 00102202 FFFFF234 00000022 4
I 0 0 00102202 00000011 00000022 4
I 0 0 02100030 - - -
I 0 0 00384184 00000042 00000007 3
W 2 00000200
I 0 0 00084082 00000200 00000011 1
I 1 0 00102F82 00000011 00000200 41
I 3 5 00F80028 00000055 000000A5 55
